//--- all.f
+incdir+include
design/mmu_pkg.sv
design/way_result_if.sv
design/ptg_search.sv
design/ptg_way.sv
design/hit_select.sv
design/ptw_lookup_top.sv
test/tb_ptw_lookup.sv

//--- design/hit_select.sv
// Hit combiner for the two hash ways
// Picks the primary hit, then the secondary hit, else reports a miss.
// Registers the response and stalls the ways until it is taken

`timescale 1ns/1ps
`default_nettype none

`include "mmu_defs.svh"

module hit_select import mmu_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	way_result_if.sink  pri,
	way_result_if.sink  sec,
	output logic        rsp_valid,
	input  logic        rsp_ready,
	output logic        rsp_found,
	output logic        rsp_secondary,
	output logic [1:0]  rsp_slot,
	output pte_t        rsp_pte
);

	logic        stall;
	way_result_t pick;
	logic        pick_secondary;
	logic [1:0]  pick_slot;

	// ==============================
	// Back-pressure
	// ==============================

	// A response that is not taken freezes the whole pipe
	assign stall = rsp_valid && !rsp_ready;
	assign pri.stall = stall;
	assign sec.stall = stall;

	// ==============================
	// Priority choice
	// ==============================

	// Primary first. A miss in both ways returns a zero entry and slot
	always_comb begin
		pick = '0;
		pick_secondary = `FALSE;
		pick_slot = '0;
		if (pri.found) begin
			pick.found = `TRUE;
			pick.pte = pri.pte;
			pick_slot = pri.slot;
		end else if (sec.found) begin
			pick.found = `TRUE;
			pick.pte = sec.pte;
			pick_secondary = `TRUE;
			pick_slot = sec.slot;
		end
	end

	// Both ways advance together, so their valids are in step
	always_ff @(posedge clk) begin
		if (reset) begin
			rsp_valid <= `FALSE;
		end else if (!stall) begin
			rsp_valid <= pri.valid && sec.valid;
		end
	end

	// Response payload, held while stalled
	always_ff @(posedge clk) begin
		if (!stall) begin
			rsp_found <= pick.found;
			rsp_pte <= pick.pte;
			rsp_secondary <= pick_secondary;
			rsp_slot <= pick_slot;
		end
	end

endmodule

`default_nettype wire

//--- design/mmu_pkg.sv
// MMU package for the hashed page table walker
// Holds the page table entry and group layouts, the two views of a
// virtual address and the search result of one way

`default_nettype none

package mmu_pkg;

	// ==============================
	// Group geometry
	// ==============================

	// Entries held in one page table group, searched in parallel
	localparam int PTE_PER_PTG = 4;

	// ==============================
	// Page table entry
	// ==============================

	// One translation. The full 20 bit vpn is stored even for a superpage,
	// which only compares its upper ten bits
	typedef struct packed {
		logic        v;
		logic        g;
		logic        s;
		logic [7:0]  asid;
		logic [19:0] vpn;
		logic [19:0] ppn;
	} pte_t;

	// A group is read from the table as one wide word
	typedef pte_t [PTE_PER_PTG-1:0] ptg_t;

	// ==============================
	// Virtual address views
	// ==============================

	// 4 KB page view
	typedef struct packed {
		logic [19:0] vpn;
		logic [11:0] offset;
	} page_view_t;

	// 4 MB superpage view
	typedef struct packed {
		logic [9:0]  vpn_hi;
		logic [21:0] offset;
	} super_view_t;

	// The same 32 bit miss address decoded either way
	typedef union packed {
		page_view_t  page;
		super_view_t superpg;
	} virtual_address_t;

	// Chosen translation before it is registered at the response port
	typedef struct packed {
		logic found;
		pte_t pte;
	} way_result_t;

endpackage

`default_nettype wire

//--- design/ptg_search.sv
// Page table group search
// Scans the four entries of one group and returns the first valid entry
// that matches the miss address and ASID. Purely combinational

`timescale 1ns/1ps
`default_nettype none

`include "mmu_defs.svh"

module ptg_search import mmu_pkg::*; (
	input  ptg_t             ptg,
	input  logic [7:0]       asid,
	input  virtual_address_t miss_adr,
	output pte_t             pte,
	output logic [1:0]       slot,
	output logic             found
);

	// Per entry match flags
	logic [PTE_PER_PTG-1:0] hit;

	// The upper ten bits always take part in the compare.
	// A superpage ignores the lower ten and a global entry ignores the ASID
	always_comb begin
		for (int k = 0; k < PTE_PER_PTG; k++) begin
			hit[k] = ptg[k].v
				&& ptg[k].vpn[19:10] == miss_adr.superpg.vpn_hi
				&& (ptg[k].s || ptg[k].vpn[9:0] == miss_adr.page.vpn[9:0])
				&& (ptg[k].g || ptg[k].asid == asid);
		end
	end

	// Lowest slot wins when several entries match
	// A miss leaves the entry and slot at zero
	always_comb begin
		found = `FALSE;
		pte = '0;
		slot = '0;
		for (int k = 0; k < PTE_PER_PTG; k++) begin
			if (!found && hit[k]) begin
				found = `TRUE;
				pte = ptg[k];
				slot = 2'(k);
			end
		end
	end

endmodule

`default_nettype wire

//--- design/ptg_way.sv
// Hash way of the page table walker
// Hashes the miss address into a group index, reads the group RAM,
// searches the group and registers the result towards the combiner.
// The secondary way uses the complemented index

`timescale 1ns/1ps
`default_nettype none

`include "mmu_defs.svh"

module ptg_way import mmu_pkg::*; #(
	parameter int GROUP_BITS = 6,
	parameter bit SECONDARY  = 1'b0
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  advance,
	input  virtual_address_t      vadr,
	input  logic [7:0]            asid,
	input  logic                  wr_en,
	input  logic                  wr_secondary,
	input  logic [GROUP_BITS-1:0] wr_group,
	input  logic [1:0]            wr_slot,
	input  pte_t                  wr_pte,
	way_result_if.source          res
);

	localparam int GROUPS = 1 << GROUP_BITS;

	// ==============================
	// Hash and group RAM
	// ==============================

	logic [9:0]            hash_full;
	logic [GROUP_BITS-1:0] rd_group;

	// Group table, one wide word per group. Not cleared at reset
	ptg_t ram [GROUPS];

	// Upper VPN bits mixed with the ASID, low bits kept as the index
	assign hash_full = vadr.superpg.vpn_hi ^ {2'b00, asid};
	assign rd_group = SECONDARY ? ~hash_full[GROUP_BITS-1:0]
		: hash_full[GROUP_BITS-1:0];

	// Write port, one entry at a time. Only the way named by wr_secondary
	// takes the write
	always_ff @(posedge clk) begin
		if (wr_en && wr_secondary == SECONDARY) begin
			ram[wr_group][wr_slot] <= wr_pte;
		end
	end

	// ==============================
	// Stage 1, RAM read
	// ==============================

	logic             s1_valid;
	ptg_t             s1_ptg;
	virtual_address_t s1_vadr;
	logic [7:0]       s1_asid;

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= `FALSE;
		end else if (!res.stall) begin
			s1_valid <= advance;
		end
	end

	// The read samples the table before a write at the same edge lands
	always_ff @(posedge clk) begin
		if (!res.stall) begin
			s1_ptg <= ram[rd_group];
			s1_vadr <= vadr;
			s1_asid <= asid;
		end
	end

	// ==============================
	// Stage 2, search result
	// ==============================

	pte_t       srch_pte;
	logic [1:0] srch_slot;
	logic       srch_found;

	ptg_search u_search (
		.ptg      (s1_ptg),
		.asid     (s1_asid),
		.miss_adr (s1_vadr),
		.pte      (srch_pte),
		.slot     (srch_slot),
		.found    (srch_found)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			res.valid <= `FALSE;
			res.found <= `FALSE;
		end else if (!res.stall) begin
			res.valid <= s1_valid;
			res.found <= srch_found;
		end
	end

	// Entry and slot travel alongside the flags
	always_ff @(posedge clk) begin
		if (!res.stall) begin
			res.pte <= srch_pte;
			res.slot <= srch_slot;
		end
	end

endmodule

`default_nettype wire

//--- design/ptw_lookup_top.sv
// Hashed page table walker lookup
// Two hash ways search their group tables side by side and a combiner
// returns one response per request, in order, three cycles later

`timescale 1ns/1ps
`default_nettype none

module ptw_lookup_top import mmu_pkg::*; #(
	parameter int GROUP_BITS = 6
) (
	input  logic                  clk,
	input  logic                  reset,

	// Lookup request from the TLB miss path
	input  logic                  req_valid,
	output logic                  req_ready,
	input  virtual_address_t      req_vadr,
	input  logic [7:0]            req_asid,

	// Lookup response
	output logic                  rsp_valid,
	input  logic                  rsp_ready,
	output logic                  rsp_found,
	output logic                  rsp_secondary,
	output logic [1:0]            rsp_slot,
	output pte_t                  rsp_pte,

	// Table write port
	input  logic                  wr_en,
	input  logic                  wr_secondary,
	input  logic [GROUP_BITS-1:0] wr_group,
	input  logic [1:0]            wr_slot,
	input  pte_t                  wr_pte
);

	logic advance;

	way_result_if pri_res ();
	way_result_if sec_res ();

	// Requests are refused only while the response is blocked
	assign req_ready = !pri_res.stall;
	assign advance = req_valid && req_ready;

	// ==============================
	// Hash ways
	// ==============================

	ptg_way #(.GROUP_BITS(GROUP_BITS), .SECONDARY(1'b0)) u_pri_way (
		.clk          (clk),
		.reset        (reset),
		.advance      (advance),
		.vadr         (req_vadr),
		.asid         (req_asid),
		.wr_en        (wr_en),
		.wr_secondary (wr_secondary),
		.wr_group     (wr_group),
		.wr_slot      (wr_slot),
		.wr_pte       (wr_pte),
		.res          (pri_res.source)
	);

	ptg_way #(.GROUP_BITS(GROUP_BITS), .SECONDARY(1'b1)) u_sec_way (
		.clk          (clk),
		.reset        (reset),
		.advance      (advance),
		.vadr         (req_vadr),
		.asid         (req_asid),
		.wr_en        (wr_en),
		.wr_secondary (wr_secondary),
		.wr_group     (wr_group),
		.wr_slot      (wr_slot),
		.wr_pte       (wr_pte),
		.res          (sec_res.source)
	);

	// ==============================
	// Combiner
	// ==============================

	hit_select u_hit_select (
		.clk           (clk),
		.reset         (reset),
		.pri           (pri_res.sink),
		.sec           (sec_res.sink),
		.rsp_valid     (rsp_valid),
		.rsp_ready     (rsp_ready),
		.rsp_found     (rsp_found),
		.rsp_secondary (rsp_secondary),
		.rsp_slot      (rsp_slot),
		.rsp_pte       (rsp_pte)
	);

endmodule

`default_nettype wire

//--- design/way_result_if.sv
// Way result interface
// Carries the registered search result of one hash way to the combiner
// and returns the pipeline stall from the combiner

`timescale 1ns/1ps
`default_nettype none

interface way_result_if import mmu_pkg::*; ();

	// Result of the group search, one entry per lookup in flight
	logic       valid;
	logic       found;
	pte_t       pte;
	logic [1:0] slot;

	// High while the response port is blocked. Every stage holds
	logic       stall;

	// The way drives the result and obeys stall
	modport source (
		output valid, found, pte, slot,
		input  stall
	);

	// The combiner reads the result and owns stall
	modport sink (
		input  valid, found, pte, slot,
		output stall
	);

endinterface

`default_nettype wire

//--- include/mmu_defs.svh
// Shared one bit constants for the MMU walker logic
// Included by the RTL that sets and tests flags

`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// Flag values
`define TRUE  1'b1
`define FALSE 1'b0

`endif

//--- run.sh
#!/bin/sh
# Builds the walker testbench with Verilator, runs it and scans the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	-f all.f \
	--top-module tb_ptw_lookup \
	-o sim_tb_ptw_lookup

# The simulator may exit non-zero on failure, the log decides the result
./obj_dir/sim_tb_ptw_lookup > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
	echo "Simulation FAILED"
	exit 1
fi

echo "Simulation PASSED"

//--- test/tb_ptw_lookup.sv
// Testbench for the hashed page table walker lookup
// Loads both group tables, then sends random lookups and checks every
// response in order against a model of the tables and the priority rule

`timescale 1ns/1ps
`default_nettype none

module tb_ptw_lookup import mmu_pkg::*; ();

	localparam int GROUP_BITS = 6;
	localparam int GROUPS = 1 << GROUP_BITS;
	localparam int LOOKUPS_PLAIN = 300;
	localparam int LOOKUPS_BP = 400;
	localparam int CLK_NS = 4;
	// A lookup places at most three entries and may wait under back-pressure
	localparam int CYCLES_PER_OP = 40;
	localparam int TOTAL_OPS = 2 * GROUPS * PTE_PER_PTG + LOOKUPS_PLAIN + LOOKUPS_BP;
	localparam int TIMEOUT_NS = TOTAL_OPS * CYCLES_PER_OP * CLK_NS;
	// Three stages in flight with the response port always ready, plus margin
	localparam int DRAIN_CYCLES = 8;

	// One expected response, in the order of acceptance
	typedef struct packed {
		logic       found;
		logic       secondary;
		logic [1:0] slot;
		pte_t       pte;
	} expect_t;

	logic                  clk;
	logic                  reset;
	logic                  req_valid;
	logic                  req_ready;
	virtual_address_t      req_vadr;
	logic [7:0]            req_asid;
	logic                  rsp_valid;
	logic                  rsp_ready;
	logic                  rsp_found;
	logic                  rsp_secondary;
	logic [1:0]            rsp_slot;
	pte_t                  rsp_pte;
	logic                  wr_en;
	logic                  wr_secondary;
	logic [GROUP_BITS-1:0] wr_group;
	logic [1:0]            wr_slot;
	pte_t                  wr_pte;

	integer  seed;
	bit      backpressure;
	expect_t head;
	expect_t exp_q [$];

	// Model of both tables, index 0 is the primary way
	pte_t model_tbl [2][GROUPS][PTE_PER_PTG];

	ptw_lookup_top #(.GROUP_BITS(GROUP_BITS)) uut (
		.clk           (clk),
		.reset         (reset),
		.req_valid     (req_valid),
		.req_ready     (req_ready),
		.req_vadr      (req_vadr),
		.req_asid      (req_asid),
		.rsp_valid     (rsp_valid),
		.rsp_ready     (rsp_ready),
		.rsp_found     (rsp_found),
		.rsp_secondary (rsp_secondary),
		.rsp_slot      (rsp_slot),
		.rsp_pte       (rsp_pte),
		.wr_en         (wr_en),
		.wr_secondary  (wr_secondary),
		.wr_group      (wr_group),
		.wr_slot       (wr_slot),
		.wr_pte        (wr_pte)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// ==============================
	// Model
	// ==============================

	// Low bits of the upper VPN half mixed with the ASID, inverted for the secondary
	function automatic logic [GROUP_BITS-1:0] group_of(logic [19:0] vpn, logic [7:0] asid,
		bit sec);
		logic [GROUP_BITS-1:0] idx;
		idx = vpn[10 +: GROUP_BITS] ^ asid[GROUP_BITS-1:0];
		return sec ? ~idx : idx;
	endfunction

	function automatic bit entry_matches(pte_t e, logic [19:0] vpn, logic [7:0] asid);
		bit hi_ok;
		bit lo_ok;
		bit asid_ok;
		hi_ok = e.vpn[19:10] == vpn[19:10];
		// Superpages only look at the upper half
		lo_ok = e.s || (e.vpn[9:0] == vpn[9:0]);
		asid_ok = e.g || (e.asid == asid);
		return e.v && hi_ok && lo_ok && asid_ok;
	endfunction

	// Primary way first, lowest slot first, zero result on a miss
	function automatic expect_t predict(logic [19:0] vpn, logic [7:0] asid);
		expect_t r;
		logic [GROUP_BITS-1:0] grp;
		r = '0;
		for (int w = 0; w < 2; w++) begin
			grp = group_of(vpn, asid, 1'(w));
			for (int s = 0; s < PTE_PER_PTG; s++) begin
				if (!r.found && entry_matches(model_tbl[w][grp][s], vpn, asid)) begin
					r.found = 1'b1;
					r.secondary = 1'(w);
					r.slot = 2'(s);
					r.pte = model_tbl[w][grp][s];
				end
			end
		end
		return r;
	endfunction

	// ==============================
	// Stimulus helpers
	// ==============================

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	// Response port takes three of four cycles under back-pressure
	function automatic bit ready_now();
		return !backpressure || (rand32() % 4 != 0);
	endfunction

	function automatic pte_t random_entry();
		logic [63:0] bits;
		bits = {rand32(), rand32()};
		return bits[$bits(pte_t)-1:0];
	endfunction

	// A valid entry that matches the key exactly
	function automatic pte_t key_entry(logic [19:0] vpn, logic [7:0] asid);
		pte_t e;
		e = random_entry();
		e.v = 1'b1;
		e.g = 1'b0;
		e.s = 1'b0;
		e.vpn = vpn;
		e.asid = asid;
		return e;
	endfunction

	task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			$display("Errors found");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// One cycle of table write, no request
	task automatic write_entry(bit sec, logic [GROUP_BITS-1:0] grp, logic [1:0] slot, pte_t e);
		@(posedge clk);
		#1;
		req_valid = 1'b0;
		rsp_ready = ready_now();
		wr_en = 1'b1;
		wr_secondary = sec;
		wr_group = grp;
		wr_slot = slot;
		wr_pte = e;
	endtask

	// Holds the request until the coming edge accepts it
	task automatic send_lookup(logic [19:0] vpn, logic [7:0] asid);
		logic [31:0] r;
		r = rand32();
		@(posedge clk);
		#1;
		wr_en = 1'b0;
		req_valid = 1'b1;
		req_vadr.page.vpn = vpn;
		req_vadr.page.offset = r[11:0];
		req_asid = asid;
		rsp_ready = ready_now();
		// A write in the same cycle must not be seen by this lookup
		if (backpressure && r[13:12] == 2'b00) begin
			wr_en = 1'b1;
			wr_secondary = 1'b0;
			wr_group = group_of(vpn, asid, 1'b0);
			wr_slot = 2'b00;
			wr_pte = key_entry(vpn, asid);
		end
		@(negedge clk);
		while (!req_ready) begin
			@(posedge clk);
			#1;
			rsp_ready = ready_now();
			@(negedge clk);
		end
	endtask

	// Places entries for a random key as one of five cases, then looks it up
	task automatic run_lookup();
		logic [31:0] r;
		logic [31:0] sel;
		logic [19:0] vpn;
		logic [7:0]  asid;
		pte_t        e;
		int          kind;
		r = rand32();
		sel = rand32();
		vpn = r[19:0];
		asid = r[27:20];
		kind = int'(sel[31:8] % 5);
		case (kind)
			// Plain hit in the primary way
			0: write_entry(1'b0, group_of(vpn, asid, 1'b0), sel[1:0], key_entry(vpn, asid));
			// Random v, g and s with low VPN bits and ASID that may differ
			1: begin
				e = random_entry();
				e.vpn[19:10] = vpn[19:10];
				if (sel[6]) begin
					e.vpn[9:0] = vpn[9:0];
				end
				if (sel[7]) begin
					e.asid = asid;
				end
				write_entry(1'b0, group_of(vpn, asid, 1'b0), sel[1:0], e);
			end
			// Same key in the secondary way and in two primary slots
			2: begin
				write_entry(1'b1, group_of(vpn, asid, 1'b1), sel[1:0], key_entry(vpn, asid));
				write_entry(1'b0, group_of(vpn, asid, 1'b0), sel[3:2], key_entry(vpn, asid));
				write_entry(1'b0, group_of(vpn, asid, 1'b0), sel[5:4], key_entry(vpn, asid));
			end
			// Secondary only, the primary copy is invalid
			3: begin
				e = key_entry(vpn, asid);
				write_entry(1'b1, group_of(vpn, asid, 1'b1), sel[1:0], e);
				e.v = 1'b0;
				write_entry(1'b0, group_of(vpn, asid, 1'b0), sel[3:2], e);
			end
			default: begin
				// Key left out of both tables
			end
		endcase
		send_lookup(vpn, asid);
	endtask

	// Stops requests and lets every response leave
	// Lookups still queued after the pipe has emptied were lost
	task automatic drain();
		int waited;
		@(posedge clk);
		#1;
		req_valid = 1'b0;
		wr_en = 1'b0;
		rsp_ready = 1'b1;
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
			@(posedge clk);
			waited++;
		end
		check_value("outstanding lookups", 64'(exp_q.size()), 64'(0));
		// A few idle cycles so that a stray extra response is caught
		repeat (4) @(posedge clk);
	endtask

	// ==============================
	// Monitor
	// ==============================

	// Inputs settle 1 ns after the edge, so the negedge sees what the next edge takes
	always @(negedge clk) begin
		if (!reset) begin
			if (rsp_valid && rsp_ready) begin
				if (exp_q.size() == 0) begin
					$display("A response arrived with no lookup outstanding");
					$display("Errors found");
					$fatal(1, "Unexpected response");
				end else begin
					head = exp_q.pop_front();
					check_value("rsp_found", 64'(rsp_found), 64'(head.found));
					check_value("rsp_secondary", 64'(rsp_secondary), 64'(head.secondary));
					check_value("rsp_slot", 64'(rsp_slot), 64'(head.slot));
					check_value("rsp_pte", 64'(rsp_pte), 64'(head.pte));
				end
			end
			// Prediction uses the table before a write at the same edge
			if (req_valid && req_ready) begin
				exp_q.push_back(predict(req_vadr.page.vpn, req_asid));
			end
			if (wr_en) begin
				model_tbl[wr_secondary][wr_group][wr_slot] = wr_pte;
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired before all lookups completed");
		$display("Errors found");
		$fatal(1, "Timeout");
	end

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		seed = 56;
		backpressure = 1'b0;
		reset = 1'b1;
		req_valid = 1'b0;
		req_vadr = '0;
		req_asid = '0;
		rsp_ready = 1'b1;
		wr_en = 1'b0;
		wr_secondary = 1'b0;
		wr_group = '0;
		wr_slot = '0;
		wr_pte = '0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		// Every entry of both tables gets random contents
		for (int w = 0; w < 2; w++) begin
			for (int g = 0; g < GROUPS; g++) begin
				for (int s = 0; s < PTE_PER_PTG; s++) begin
					write_entry(1'(w), GROUP_BITS'(g), 2'(s), random_entry());
				end
			end
		end
		for (int i = 0; i < LOOKUPS_PLAIN; i++) begin
			run_lookup();
		end
		drain();
		backpressure = 1'b1;
		for (int i = 0; i < LOOKUPS_BP; i++) begin
			run_lookup();
		end
		drain();
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire
